// File: common/alu_pkg.sv
`default_nettype none

package alu_pkg;

    parameter int alu_xlen = 64;
    localparam int shamt_w = $clog2(alu_xlen);

    typedef enum logic [4:0] {
        ADD      = 5'd0,
        SUB      = 5'd1,
        RETURN_A = 5'd2,
        RETURN_B = 5'd3,
        XOR      = 5'd4,
        OR       = 5'd5,
        AND      = 5'd6,
        SLL      = 5'd7,
        SRL      = 5'd8,
        SRA      = 5'd9,
        SLT      = 5'd10,
        SLTU     = 5'd11,
        EQ       = 5'd12,
        LOE      = 5'd13,
        LOEU     = 5'd14,
        MUL      = 5'd15,
        DIV      = 5'd16,
        DIVU     = 5'd17,
        REM      = 5'd18,
        REMU     = 5'd19
    } alu_op_t;

    // single-cycle result; MUL is handled by the sequential multiplier
    function automatic logic [alu_xlen-1:0] alu_compute(
        input alu_op_t op,
        input logic [alu_xlen-1:0] a,
        input logic [alu_xlen-1:0] b,
        input logic rs1to32
    );
        logic [shamt_w-1:0] sh;
        logic [alu_xlen/2-1:0] word_sra;
        logic div_zero;
        logic div_ovf;
        sh = b[shamt_w-1:0];
        word_sra = $signed(a[alu_xlen/2-1:0]) >>> sh;
        div_zero = (b == '0);
        // most negative by minus one
        div_ovf = (a == {1'b1, {(alu_xlen-1){1'b0}}}) && (b == '1);
        case (op)
            ADD:      return a + b;
            SUB:      return a - b;
            RETURN_A: return a;
            RETURN_B: return b;
            XOR:      return a ^ b;
            OR:       return a | b;
            AND:      return a & b;
            SLL:      return a << sh;
            SRL:      return a >> sh;
            SRA: begin
                // word mode shifts the low half and zero-extends
                if (rs1to32) begin
                    return {{(alu_xlen/2){1'b0}}, word_sra};
                end
                return $signed(a) >>> sh;
            end
            SLT:      return alu_xlen'($signed(a) < $signed(b));
            SLTU:     return alu_xlen'(a < b);
            EQ:       return alu_xlen'(a == b);
            LOE:      return alu_xlen'($signed(a) >= $signed(b));
            LOEU:     return alu_xlen'(a >= b);
            DIV: begin
                if (div_zero) begin
                    return '1;
                end
                if (div_ovf) begin
                    return a;
                end
                return $signed(a) / $signed(b);
            end
            DIVU: begin
                if (div_zero) begin
                    return '1;
                end
                return a / b;
            end
            REM: begin
                if (div_zero) begin
                    return a;
                end
                if (div_ovf) begin
                    return '0;
                end
                return $signed(a) % $signed(b);
            end
            REMU: begin
                if (div_zero) begin
                    return a;
                end
                return a % b;
            end
            default:  return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/operand_pkg.sv
`default_nettype none

package operand_pkg;

    localparam int xw = alu_pkg::alu_xlen;

    typedef logic [1:0] sel_a_t;
    typedef logic [1:0] sel_b_t;

    localparam sel_a_t sel_a_pc  = 2'd0;
    localparam sel_a_t sel_a_rs1 = 2'd1;

    localparam sel_b_t sel_b_imm = 2'd0;
    localparam sel_b_t sel_b_rs2 = 2'd1;
    localparam sel_b_t sel_b_csr = 2'd2;

    // first operand, rs1 optionally cut to its low word
    function automatic logic [xw-1:0] pick_a(
        input sel_a_t sel,
        input logic [xw-1:0] pc,
        input logic [xw-1:0] rs1,
        input logic rs1to32
    );
        if (sel != sel_a_rs1) begin
            return pc;
        end
        if (rs1to32) begin
            return {{(xw/2){1'b0}}, rs1[xw/2-1:0]};
        end
        return rs1;
    endfunction

    function automatic logic [xw-1:0] pick_b(
        input sel_b_t sel,
        input logic [xw-1:0] rs2,
        input logic [xw-1:0] csr,
        input logic [xw-1:0] imm
    );
        case (sel)
            sel_b_rs2: return rs2;
            sel_b_csr: return csr;
            default:   return imm;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: mul/seq_mul.sv
`timescale 1ns/1ps
`default_nettype none

module seq_mul #(
    parameter int xlen = alu_pkg::alu_xlen
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire logic              flush,
    input  wire logic [xlen-1:0]   a,
    input  wire logic [xlen-1:0]   b,
    output logic                   ready,
    output logic                   out_valid,
    output logic [xlen/2-1:0]      hi,
    output logic [xlen/2-1:0]      lo
);

    localparam int cnt_w = $clog2(xlen);
    localparam logic [cnt_w-1:0] last_step = cnt_w'(xlen - 1);

    logic              busy;
    logic [cnt_w-1:0]  count;
    logic [xlen-1:0]   mcand;
    logic [xlen-1:0]   mplier;
    logic [xlen-1:0]   acc;
    logic              take;

    assign take = start && !busy;

    // control: the capture edge is iteration 0, count tracks the rest
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            count     <= '0;
        end else if (flush) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            count     <= '0;
        end else begin
            out_valid <= 1'b0;
            if (take) begin
                busy  <= 1'b1;
                count <= cnt_w'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == last_step) begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
            end
        end
    end

    // radix-2 shift-add, only the low xlen bits of the product are kept
    always_ff @(posedge clk) begin
        if (take) begin
            mcand  <= a << 1;
            mplier <= b >> 1;
            acc    <= b[0] ? a : '0;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
        end
    end

    assign ready = !busy;
    assign hi    = acc[xlen-1:xlen/2];
    assign lo    = acc[xlen/2-1:0];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int xlen = alu_pkg::alu_xlen
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                flush,
    input  wire logic [xlen-1:0]     pc,
    input  wire alu_pkg::alu_op_t    operate,
    input  wire logic [xlen-1:0]     rs1,
    input  wire logic [xlen-1:0]     rs2,
    input  wire logic [xlen-1:0]     csr,
    input  wire logic [xlen-1:0]     imm,
    input  wire operand_pkg::sel_a_t sel_a,
    input  wire operand_pkg::sel_b_t sel_b,
    input  wire logic                rs1to32,
    output logic [xlen-1:0]          res,
    output logic                     alu_wait
);

    typedef enum logic {
        mul_idle,
        mul_busy
    } mul_state_t;

    mul_state_t         mul_state;
    logic               mul_start;
    logic               mul_ready;
    logic               mul_out_valid;
    logic [xlen/2-1:0]  mul_hi;
    logic [xlen/2-1:0]  mul_lo;

    logic [xlen-1:0]    op_a;
    logic [xlen-1:0]    op_b;
    logic [xlen-1:0]    single_res;
    logic               is_mul;
    logic               mul_accept;
    logic               mul_done;

    // pc or rs1 on the first input, rs2/csr/imm on the second
    assign op_a = operand_pkg::pick_a(sel_a, pc, rs1, rs1to32);
    assign op_b = operand_pkg::pick_b(sel_b, rs2, csr, imm);

    assign single_res = alu_pkg::alu_compute(operate, op_a, op_b, rs1to32);

    assign is_mul     = (operate == alu_pkg::MUL);
    assign mul_accept = is_mul && (mul_state == mul_idle) && mul_ready;
    assign mul_done   = (mul_state == mul_busy) && mul_out_valid;

    seq_mul #(
        .xlen(xlen)
    ) mul_i (
        .clk      (clk),
        .rst      (rst),
        .start    (mul_start),
        .flush    (flush),
        .a        (op_a),
        .b        (op_b),
        .ready    (mul_ready),
        .out_valid(mul_out_valid),
        .hi       (mul_hi),
        .lo       (mul_lo)
    );

    // multiply sequence, start is a one-cycle pulse on acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_state <= mul_idle;
            mul_start <= 1'b0;
        end else if (flush) begin
            // abandon the multiply, the multiplier drops its result too
            mul_state <= mul_idle;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            case (mul_state)
                mul_idle: begin
                    if (mul_accept) begin
                        mul_start <= 1'b1;
                        mul_state <= mul_busy;
                    end
                end
                mul_busy: begin
                    if (mul_out_valid) begin
                        mul_state <= mul_idle;
                    end
                end
            endcase
        end
    end

    assign alu_wait = (mul_state == mul_busy);

    // one registered result per clock, product lands on out_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (!flush) begin
            if (!is_mul) begin
                res <= single_res;
            end else if (mul_done) begin
                res <= {mul_hi, mul_lo};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int xlen = alu_pkg::alu_xlen
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                flush,
    input  wire logic [xlen-1:0]     pc,
    input  wire alu_pkg::alu_op_t    operate,
    input  wire logic [xlen-1:0]     rs1,
    input  wire logic [xlen-1:0]     rs2,
    input  wire logic [xlen-1:0]     csr,
    input  wire logic [xlen-1:0]     imm,
    input  wire operand_pkg::sel_a_t sel_a,
    input  wire operand_pkg::sel_b_t sel_b,
    input  wire logic                rs1to32,
    output logic [xlen-1:0]          res,
    output logic                     alu_wait
);

    // integer execute stage, a single ALU with its multiplier
    alu #(
        .xlen(xlen)
    ) alu_i (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .pc      (pc),
        .operate (operate),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .rs1to32 (rs1to32),
        .res     (res),
        .alu_wait(alu_wait)
    );

endmodule

`default_nettype wire

// File: test/exec_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_checker (
    input wire logic                         clk,
    input wire logic                         rst,
    input wire logic                         flush,
    input wire alu_pkg::alu_op_t             operate,
    input wire logic [alu_pkg::alu_xlen-1:0] pc,
    input wire logic [alu_pkg::alu_xlen-1:0] rs1,
    input wire logic [alu_pkg::alu_xlen-1:0] rs2,
    input wire logic [alu_pkg::alu_xlen-1:0] csr,
    input wire logic [alu_pkg::alu_xlen-1:0] imm,
    input wire logic [1:0]                   sel_a,
    input wire logic [1:0]                   sel_b,
    input wire logic                         rs1to32,
    input wire logic [alu_pkg::alu_xlen-1:0] res,
    input wire logic                         alu_wait
);

    localparam int xlen = alu_pkg::alu_xlen;
    localparam int half = xlen / 2;
    localparam int sw = $clog2(xlen);

    int fail_count = 0;
    int wait_cycles;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] expect_res;
    logic [xlen-1:0] expect_prod;

    // RISC-V results, divide by zero and overflow included
    function automatic logic [xlen-1:0] reference_result(
        input alu_pkg::alu_op_t op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b,
        input logic word
    );
        logic [sw-1:0] s;
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sbv;
        logic signed [xlen-1:0] dv;
        logic signed [half-1:0] lw;
        logic [half-1:0] sra_w;
        logic [xlen-1:0] sra_x;
        logic [xlen-1:0] quo;
        logic [xlen-1:0] rem;
        logic zero;
        logic ovf;
        s = b[sw-1:0];
        sa = a;
        sbv = b;
        lw = a[half-1:0];
        sra_w = lw >>> s;
        sra_x = sa >>> s;
        zero = (b == '0);
        ovf = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        // safe divisor, the special cases are picked below
        dv = (zero || ovf) ? 1 : b;
        quo = sa / dv;
        rem = sa % dv;
        case (op)
            alu_pkg::ADD:      return a + b;
            alu_pkg::SUB:      return a - b;
            alu_pkg::RETURN_A: return a;
            alu_pkg::RETURN_B: return b;
            alu_pkg::XOR:      return a ^ b;
            alu_pkg::OR:       return a | b;
            alu_pkg::AND:      return a & b;
            alu_pkg::SLL:      return a << s;
            alu_pkg::SRL:      return a >> s;
            alu_pkg::SRA:      return word ? {{half{1'b0}}, sra_w} : sra_x;
            alu_pkg::SLT:      return xlen'(sa < sbv);
            alu_pkg::SLTU:     return xlen'(a < b);
            alu_pkg::EQ:       return xlen'(a == b);
            alu_pkg::LOE:      return xlen'(sa >= sbv);
            alu_pkg::LOEU:     return xlen'(a >= b);
            alu_pkg::DIV:      return zero ? '1 : (ovf ? a : quo);
            alu_pkg::DIVU:     return zero ? '1 : a / b;
            alu_pkg::REM:      return zero ? a : (ovf ? '0 : rem);
            alu_pkg::REMU:     return zero ? a : a % b;
            default:           return '0;
        endcase
    endfunction

    assign op_a = (sel_a == 2'd1) ? (rs1to32 ? {{half{1'b0}}, rs1[half-1:0]} : rs1) : pc;
    assign op_b = (sel_b == 2'd1) ? rs2 : ((sel_b == 2'd2) ? csr : imm);
    assign expect_res  = reference_result(operate, op_a, op_b, rs1to32);
    assign expect_prod = op_a * op_b;

    // cycles with alu_wait high in the current multiply
    always_ff @(posedge clk) begin
        if (rst || !alu_wait) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |-> (res == '0 && !alu_wait))
        else begin
            $error("res or alu_wait not cleared by reset");
            fail_count++;
        end

    a_single: assert property (@(posedge clk) disable iff (rst)
        (!flush && operate != alu_pkg::MUL) |=> (res == $past(expect_res)))
        else begin
            $error("single-cycle result differs from the reference");
            fail_count++;
        end

    a_mul_start: assert property (@(posedge clk) disable iff (rst)
        (operate == alu_pkg::MUL && !alu_wait && !flush) |=> alu_wait)
        else begin
            $error("alu_wait did not rise after a multiply was accepted");
            fail_count++;
        end

    a_mul_len: assert property (@(posedge clk) disable iff (rst)
        ($fell(alu_wait) && !$past(flush)) |-> (wait_cycles == xlen + 1))
        else begin
            $error("multiply did not take xlen+1 cycles");
            fail_count++;
        end

    a_mul_prod: assert property (@(posedge clk) disable iff (rst)
        ($fell(alu_wait) && !$past(flush)) |-> (res == $past(expect_prod)))
        else begin
            $error("product differs from the low bits of a*b");
            fail_count++;
        end

    a_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!alu_wait && res == $past(res)))
        else begin
            $error("flush did not clear alu_wait or changed res");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: test/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;

    localparam int xlen = alu_pkg::alu_xlen;
    localparam int n_codes = 21;
    // select and edge sweeps, random ops, divides, then 12 multiplies
    localparam int single_ops = 2 * 16 * n_codes + 300 + 20;
    localparam int max_cycles = single_ops + 12 * (xlen + 4) + 200;

    logic clk;
    logic rst;
    logic flush;
    logic [xlen-1:0] pc;
    alu_pkg::alu_op_t operate;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr;
    logic [xlen-1:0] imm;
    operand_pkg::sel_a_t sel_a;
    operand_pkg::sel_b_t sel_b;
    logic rs1to32;
    logic [xlen-1:0] res;
    logic alu_wait;

    int seed;
    int cycles;
    int test_num;
    int passed;
    int failed;
    int seen_fails;
    logic [xlen-1:0] edges [4];

    exec_unit #(
        .xlen(xlen)
    ) dut_i (
        .clk(clk), .rst(rst), .flush(flush), .pc(pc), .operate(operate),
        .rs1(rs1), .rs2(rs2), .csr(csr), .imm(imm),
        .sel_a(sel_a), .sel_b(sel_b), .rs1to32(rs1to32),
        .res(res), .alu_wait(alu_wait)
    );

    bind alu exec_unit_checker chk_i (
        .clk(clk), .rst(rst), .flush(flush), .operate(operate),
        .pc(pc), .rs1(rs1), .rs2(rs2), .csr(csr), .imm(imm),
        .sel_a(sel_a), .sel_b(sel_b), .rs1to32(rs1to32),
        .res(res), .alu_wait(alu_wait)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: simulation did not finish");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [xlen-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic load(input logic [xlen-1:0] a_val, input logic [xlen-1:0] b_val);
        pc = a_val;
        rs1 = a_val;
        rs2 = b_val;
        csr = b_val;
        imm = b_val;
    endtask

    task automatic scramble();
        pc = random_word();
        rs1 = random_word();
        rs2 = random_word();
        csr = random_word();
        imm = random_word();
    endtask

    // sels holds sel_b in the upper two bits
    task automatic run_op(input int code, input logic [3:0] sels, input logic word);
        operate = alu_pkg::alu_op_t'(code);
        sel_a = sels[1:0];
        sel_b = sels[3:2];
        rs1to32 = word;
        @(negedge clk);
    endtask

    task automatic multiply(input logic [xlen-1:0] x, input logic [xlen-1:0] y);
        load(x, y);
        run_op(alu_pkg::MUL, 4'b0101, 1'b0);
        while (alu_wait) begin
            @(negedge clk);
        end
        run_op(alu_pkg::ADD, 4'b0101, 1'b0);
    endtask

    task automatic finish_test(input string name);
        int fresh;
        // let the last checks fire before counting
        run_op(alu_pkg::ADD, 4'b0101, 1'b0);
        run_op(alu_pkg::ADD, 4'b0101, 1'b0);
        fresh = dut_i.alu_i.chk_i.fail_count - seen_fails;
        seen_fails += fresh;
        test_num++;
        if (fresh == 0) begin
            passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            failed++;
            $display("MISMATCH at %0d ns: test %0d %s, %0d assertion failures",
                     $time, test_num, name, fresh);
        end
    endtask

    initial begin
        int code;
        seed = 32'h3e20_e707;
        edges[0] = '0;
        edges[1] = '1;
        edges[2] = {1'b1, {(xlen-1){1'b0}}};
        edges[3] = xlen'(63);
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        operate = alu_pkg::ADD;
        load('0, '0);
        sel_a = '0;
        sel_b = '0;
        rs1to32 = 1'b0;
        cycles = 0;
        test_num = 0;
        passed = 0;
        failed = 0;
        seen_fails = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        finish_test("reset");

        scramble();
        for (int c = 0; c < n_codes; c++) begin
            if (c != alu_pkg::MUL) begin
                for (int s = 0; s < 16; s++) begin
                    run_op(c, 4'(s), s[0] ^ c[0]);
                end
            end
        end
        finish_test("select");

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                load(edges[i], edges[j]);
                for (int c = 0; c < n_codes; c++) begin
                    if (c != alu_pkg::MUL) begin
                        run_op(c, 4'b0101, c[0] ^ i[0]);
                    end
                end
            end
        end
        finish_test("edges");

        for (int n = 0; n < 300; n++) begin
            scramble();
            code = $unsigned($random(seed)) % n_codes;
            if (code == alu_pkg::MUL) begin
                code = alu_pkg::SRA;
            end
            run_op(code, 4'($random(seed)), 1'($random(seed)));
        end
        finish_test("random");

        load(random_word(), '0);
        for (int c = alu_pkg::DIV; c <= alu_pkg::REMU; c++) begin
            run_op(c, 4'b0101, 1'b0);
        end
        load({1'b1, {(xlen-1){1'b0}}}, '1);
        for (int c = alu_pkg::DIV; c <= alu_pkg::REMU; c++) begin
            run_op(c, 4'b0101, 1'b0);
        end
        finish_test("divide");

        for (int n = 0; n < 10; n++) begin
            multiply(random_word(), random_word());
        end
        multiply('1, '1);
        finish_test("mul");

        // abandon a multiply part way through
        load(random_word(), random_word());
        run_op(alu_pkg::MUL, 4'b0101, 1'b0);
        repeat (20) @(negedge clk);
        flush = 1'b1;
        operate = alu_pkg::ADD;
        @(negedge clk);
        flush = 1'b0;
        finish_test("flush");

        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_unit.f
common/alu_pkg.sv
common/operand_pkg.sv
mul/seq_mul.sv
rtl/alu.sv
rtl/exec_unit.sv
test/exec_unit_checker.sv
test/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= exec_unit_tb
FILELIST  ?= exec_unit.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
